// File: files.f
+incdir+include
hw/memory_pkg.sv
hw/load_store_unit.sv
hw/credit_fifo.sv
hw/dmem_arbiter.sv
hw/data_memory.sv
hw/memory_stage.sv
hw/memory_subsystem.sv
test/tb_clock_gen.sv
test/memory_subsystem_tb.sv

// File: hw/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_type = logic,
  parameter int DEPTH = 2
) (
  input logic clock,
  input logic reset,
  input logic push,
  input payload_type push_data,
  input logic pop,
  output payload_type pop_data,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_type buffer [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0] count;
  logic full;

  assign empty = (count == '0);
  assign full = (count == (PTR_W+1)'(DEPTH));
  assign pop_data = buffer[rd_ptr];

  always_ff @(posedge clock) begin
    if (!reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) buffer[wr_ptr] <= push_data;
  end

  // Credits upstream must keep the queue within its depth.
  a_no_overflow: assert property (@(posedge clock) disable iff (!reset) push |-> !full);
  a_no_underflow: assert property (@(posedge clock) disable iff (!reset) pop |-> !empty);

endmodule

// File: hw/data_memory.sv
`timescale 1ns/1ps

`include "memory_settings.svh"

module data_memory (
  input logic clock,
  input logic reset,
  input logic mem_req_valid,
  input memory_pkg::mem_req_type mem_req,
  output logic mem_rsp_valid,
  output memory_pkg::mem_rsp_type mem_rsp,
  output logic credit_return
);
  import memory_pkg::*;

  localparam int INDEX_W = $clog2(`MEM_DEPTH_WORDS);

  logic [`MEM_XLEN-1:0] ram [`MEM_DEPTH_WORDS];

  mem_req_type head;
  logic queue_empty;
  logic queue_pop;

  mem_req_type exec_req;
  logic exec_valid;
  logic [INDEX_W-1:0] word_index;

  // The execute register drains every cycle, so the head always moves on.
  assign queue_pop = ~queue_empty;

  credit_fifo #(
    .payload_type(mem_req_type),
    .DEPTH(`MEM_CREDITS)
  ) u_req_fifo (
    .clock(clock),
    .reset(reset),
    .push(mem_req_valid),
    .push_data(mem_req),
    .pop(queue_pop),
    .pop_data(head),
    .empty(queue_empty)
  );

  assign word_index = exec_req.addr[2 +: INDEX_W];

  always_ff @(posedge clock) begin
    if (!reset) begin
      exec_valid <= 1'b0;
      mem_rsp_valid <= 1'b0;
    end else begin
      exec_valid <= queue_pop;
      mem_rsp_valid <= exec_valid; // Stores answer too.
    end
  end

  always_ff @(posedge clock) begin
    if (queue_pop) exec_req <= head;
    if (exec_valid && exec_req.write) begin
      for (int i = 0; i < `MEM_XLEN/8; i++) begin
        if (exec_req.strobe[i]) ram[word_index][8*i +: 8] <= exec_req.wdata[8*i +: 8];
      end
    end
    mem_rsp.rdata <= ram[word_index];
  end

  // One credit comes back with every response.
  assign credit_return = mem_rsp_valid;

endmodule

// File: hw/dmem_arbiter.sv
`timescale 1ns/1ps

`include "memory_settings.svh"

module dmem_arbiter (
  input logic clock,
  input logic reset,
  input logic req_valid0,
  input memory_pkg::mem_req_type req0,
  output logic req_grant0,
  output logic rsp_valid0,
  output memory_pkg::mem_rsp_type rsp0,
  input logic req_valid1,
  input memory_pkg::mem_req_type req1,
  output logic req_grant1,
  output logic rsp_valid1,
  output memory_pkg::mem_rsp_type rsp1,
  output logic mem_req_valid,
  output memory_pkg::mem_req_type mem_req,
  input logic mem_rsp_valid,
  input memory_pkg::mem_rsp_type mem_rsp,
  input logic credit_return
);
  import memory_pkg::*;

  localparam int CREDIT_W = $clog2(`MEM_CREDITS + 1);

  logic [CREDIT_W-1:0] credits;
  logic have_credit;
  slot_id_type grant_slot;
  slot_id_type route_slot;
  logic route_empty;

  // Registered count only, so a returning credit is usable next cycle.
  assign have_credit = (credits != '0);

  assign req_grant0 = have_credit & req_valid0; // Older slot always wins.
  assign req_grant1 = have_credit & req_valid1 & ~req_valid0;

  assign mem_req_valid = req_grant0 | req_grant1;
  assign mem_req = req_valid0 ? req0 : req1;
  assign grant_slot = req_valid0 ? SLOT0 : SLOT1;

  always_ff @(posedge clock) begin
    if (!reset) begin
      credits <= CREDIT_W'(`MEM_CREDITS);
    end else begin
      case ({mem_req_valid, credit_return})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Memory answers in order, so a queue of slot tags is enough.
  credit_fifo #(
    .payload_type(slot_id_type),
    .DEPTH(`MEM_ROUTE_DEPTH)
  ) u_route_fifo (
    .clock(clock),
    .reset(reset),
    .push(mem_req_valid),
    .push_data(grant_slot),
    .pop(mem_rsp_valid),
    .pop_data(route_slot),
    .empty(route_empty)
  );

  assign rsp_valid0 = mem_rsp_valid & (route_slot == SLOT0);
  assign rsp_valid1 = mem_rsp_valid & (route_slot == SLOT1);
  assign rsp0 = mem_rsp;
  assign rsp1 = mem_rsp;

  a_credit_bound: assert property (@(posedge clock) disable iff (!reset)
    credits <= CREDIT_W'(`MEM_CREDITS));
  a_rsp_routed: assert property (@(posedge clock) disable iff (!reset)
    mem_rsp_valid |-> !route_empty);

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ps

`include "memory_settings.svh"

module load_store_unit (
  input memory_pkg::slot_op_type op,
  input logic [`MEM_XLEN-1:0] rdata,
  output logic [`MEM_XLEN-1:0] wdata,
  output logic [`MEM_XLEN/8-1:0] strobe,
  output logic [`MEM_XLEN-1:0] result
);
  import memory_pkg::*;

  logic [`MEM_XLEN-1:0] byte_lane;
  logic [`MEM_XLEN-1:0] half_lane;
  logic byte_sign;
  logic half_sign;

  // Move the addressed lane down to bit 0.
  assign byte_lane = rdata >> {op.addr[1:0], 3'b000};
  assign half_lane = rdata >> {op.addr[1], 4'b0000};

  assign byte_sign = byte_lane[7] & ~op.is_unsigned;
  assign half_sign = half_lane[15] & ~op.is_unsigned;

  always_comb begin
    case (op.size)
      SIZE_BYTE: begin
        wdata = {4{op.data[7:0]}};
        strobe = 4'b0001 << op.addr[1:0];
        result = {{24{byte_sign}}, byte_lane[7:0]};
      end
      SIZE_HALF: begin
        wdata = {2{op.data[15:0]}};
        strobe = 4'b0011 << {op.addr[1], 1'b0};
        result = {{16{half_sign}}, half_lane[15:0]};
      end
      default: begin // Word.
        wdata = op.data;
        strobe = 4'b1111;
        result = rdata;
      end
    endcase
  end

endmodule

// File: hw/memory_pkg.sv
`include "memory_settings.svh"

package memory_pkg;

  typedef enum logic [1:0] {
    KIND_NONE,
    KIND_ALU,
    KIND_LOAD,
    KIND_STORE
  } mem_kind_type;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_type;

  // One operation of an issue pair.
  typedef struct packed {
    mem_kind_type kind;
    mem_size_type size;
    logic is_unsigned; // Zero-extend loads.
    logic [4:0] rd;
    logic [`MEM_XLEN-1:0] addr;
    logic [`MEM_XLEN-1:0] data; // Store data or ALU result.
  } slot_op_type;

  typedef struct packed {
    logic [`MEM_XLEN-1:0] addr;
    logic [`MEM_XLEN-1:0] wdata;
    logic [`MEM_XLEN/8-1:0] strobe;
    logic write;
  } mem_req_type;

  typedef struct packed {
    logic [`MEM_XLEN-1:0] rdata;
  } mem_rsp_type;

  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [`MEM_XLEN-1:0] wdata;
  } reg_write_type;

  // Tags a memory request with the slot that issued it.
  typedef enum logic {
    SLOT0,
    SLOT1
  } slot_id_type;

endpackage

// File: hw/memory_stage.sv
`timescale 1ns/1ps

`include "memory_settings.svh"

module memory_stage (
  input logic clock,
  input logic reset,
  input logic in_valid,
  input memory_pkg::slot_op_type in_slot0,
  input memory_pkg::slot_op_type in_slot1,
  output logic in_ready,
  output logic req_valid0,
  output memory_pkg::mem_req_type req0,
  input logic req_grant0,
  input logic rsp_valid0,
  input memory_pkg::mem_rsp_type rsp0,
  output logic req_valid1,
  output memory_pkg::mem_req_type req1,
  input logic req_grant1,
  input logic rsp_valid1,
  input memory_pkg::mem_rsp_type rsp1,
  output memory_pkg::reg_write_type wb0,
  output memory_pkg::reg_write_type wb1
);
  import memory_pkg::*;

  slot_op_type slot0_q;
  slot_op_type slot1_q;
  logic [`MEM_XLEN-1:0] result0;
  logic [`MEM_XLEN-1:0] result1;
  logic [`MEM_XLEN-1:0] lsu_wdata0;
  logic [`MEM_XLEN-1:0] lsu_wdata1;
  logic [`MEM_XLEN/8-1:0] lsu_strobe0;
  logic [`MEM_XLEN/8-1:0] lsu_strobe1;
  logic [`MEM_XLEN-1:0] lsu_result0;
  logic [`MEM_XLEN-1:0] lsu_result1;

  logic out_of_reset;
  logic busy;
  logic pending0, pending1; // Request not yet granted.
  logic waiting0, waiting1; // Granted with the response outstanding.
  logic accept;
  logic done;

  function automatic logic uses_memory(slot_op_type op);
    return (op.kind == KIND_LOAD) || (op.kind == KIND_STORE);
  endfunction

  function automatic mem_req_type make_request(slot_op_type op, logic [`MEM_XLEN-1:0] wdata,
                                               logic [`MEM_XLEN/8-1:0] strobe);
    mem_req_type req;
    req.addr = op.addr;
    req.wdata = wdata;
    req.write = (op.kind == KIND_STORE);
    req.strobe = req.write ? strobe : '0;
    return req;
  endfunction

  // Writes to x0 are dropped here.
  function automatic reg_write_type make_write(slot_op_type op, logic [`MEM_XLEN-1:0] load_data,
                                               logic fire);
    reg_write_type wb;
    wb.wren = fire && (op.kind == KIND_ALU || op.kind == KIND_LOAD) && (op.rd != '0);
    wb.waddr = op.rd;
    wb.wdata = (op.kind == KIND_LOAD) ? load_data : op.data;
    return wb;
  endfunction

  load_store_unit u_lsu0 (.op(slot0_q), .rdata(rsp0.rdata), .wdata(lsu_wdata0),
                          .strobe(lsu_strobe0), .result(lsu_result0));
  load_store_unit u_lsu1 (.op(slot1_q), .rdata(rsp1.rdata), .wdata(lsu_wdata1),
                          .strobe(lsu_strobe1), .result(lsu_result1));

  assign in_ready = out_of_reset & ~(pending0 | pending1 | waiting0 | waiting1);
  assign accept = in_valid & in_ready;
  assign done = busy & in_ready; // Pair complete and ready to write back.

  assign req_valid0 = pending0;
  assign req_valid1 = pending1;
  assign req0 = make_request(slot0_q, lsu_wdata0, lsu_strobe0);
  assign req1 = make_request(slot1_q, lsu_wdata1, lsu_strobe1);

  assign wb0 = make_write(slot0_q, result0, done);
  assign wb1 = make_write(slot1_q, result1, done);

  always_ff @(posedge clock) begin
    if (!reset) begin
      out_of_reset <= 1'b0;
      busy <= 1'b0;
      pending0 <= 1'b0;
      pending1 <= 1'b0;
      waiting0 <= 1'b0;
      waiting1 <= 1'b0;
    end else begin
      out_of_reset <= 1'b1;
      if (req_grant0) pending0 <= 1'b0;
      if (req_grant1) pending1 <= 1'b0;
      if (req_grant0) waiting0 <= 1'b1;
      else if (rsp_valid0) waiting0 <= 1'b0;
      if (req_grant1) waiting1 <= 1'b1;
      else if (rsp_valid1) waiting1 <= 1'b0;
      if (accept) begin
        busy <= 1'b1;
        pending0 <= uses_memory(in_slot0);
        pending1 <= uses_memory(in_slot1);
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slot0_q <= in_slot0;
      slot1_q <= in_slot1;
    end
    if (rsp_valid0) result0 <= lsu_result0;
    if (rsp_valid1) result1 <= lsu_result1;
  end

  a_rsp0_expected: assert property (@(posedge clock) disable iff (!reset) rsp_valid0 |-> waiting0);
  a_rsp1_expected: assert property (@(posedge clock) disable iff (!reset) rsp_valid1 |-> waiting1);

endmodule

// File: hw/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem (
  input logic clock,
  input logic reset,
  input logic in_valid,
  input memory_pkg::slot_op_type in_slot0,
  input memory_pkg::slot_op_type in_slot1,
  output logic in_ready,
  output memory_pkg::reg_write_type wb0,
  output memory_pkg::reg_write_type wb1
);
  import memory_pkg::*;

  logic req_valid0, req_grant0, rsp_valid0;
  logic req_valid1, req_grant1, rsp_valid1;
  mem_req_type req0, req1;
  mem_rsp_type rsp0, rsp1;

  logic mem_req_valid, mem_rsp_valid, credit_return;
  mem_req_type mem_req;
  mem_rsp_type mem_rsp;

  memory_stage u_stage (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_slot0(in_slot0), .in_slot1(in_slot1), .in_ready(in_ready),
    .req_valid0(req_valid0), .req0(req0), .req_grant0(req_grant0),
    .rsp_valid0(rsp_valid0), .rsp0(rsp0),
    .req_valid1(req_valid1), .req1(req1), .req_grant1(req_grant1),
    .rsp_valid1(rsp_valid1), .rsp1(rsp1),
    .wb0(wb0), .wb1(wb1)
  );

  dmem_arbiter u_arbiter (
    .clock(clock), .reset(reset),
    .req_valid0(req_valid0), .req0(req0), .req_grant0(req_grant0),
    .rsp_valid0(rsp_valid0), .rsp0(rsp0),
    .req_valid1(req_valid1), .req1(req1), .req_grant1(req_grant1),
    .rsp_valid1(rsp_valid1), .rsp1(rsp1),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp), .credit_return(credit_return)
  );

  data_memory u_memory (
    .clock(clock), .reset(reset),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req),
    .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp), .credit_return(credit_return)
  );

endmodule

// File: include/memory_settings.svh
`ifndef MEMORY_SETTINGS_SVH
`define MEMORY_SETTINGS_SVH

// Data and address width.
`define MEM_XLEN 32

// RAM size in words.
`define MEM_DEPTH_WORDS 256

`define MEM_CREDITS 2 // Request queue depth and starting credit count.

// Response routing queue of at least MEM_CREDITS entries.
`define MEM_ROUTE_DEPTH 2

`endif

// File: run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
  --top-module memory_subsystem_tb --Mdir obj_dir -o memory_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/memory_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished with status 0"
exit 0

// File: test/memory_subsystem_tb.sv
`timescale 1ns/1ps

module memory_subsystem_tb;
  import memory_pkg::*;

  localparam int FIELDS = 18; // Per trace line.
  localparam int MAX_PAIRS = 64;
  localparam int TRACE_WORDS = 1 + MAX_PAIRS * FIELDS;
  localparam int CYCLES_PER_PAIR = 20;

  logic clock;
  logic reset;
  logic in_valid;
  slot_op_type in_slot0;
  slot_op_type in_slot1;
  logic in_ready;
  reg_write_type wb0;
  reg_write_type wb1;

  logic [31:0] trace_mem [0:TRACE_WORDS-1];
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  memory_subsystem u_dut (
    .clock(clock), .reset(reset),
    .in_valid(in_valid), .in_slot0(in_slot0), .in_slot1(in_slot1), .in_ready(in_ready),
    .wb0(wb0), .wb1(wb1)
  );

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  // Six hex fields per slot in trace column order.
  function automatic slot_op_type build_op(int base);
    slot_op_type op;
    op.kind = mem_kind_type'(trace_mem[base][1:0]);
    op.size = mem_size_type'(trace_mem[base+1][1:0]);
    op.is_unsigned = trace_mem[base+2][0];
    op.rd = trace_mem[base+3][4:0];
    op.addr = trace_mem[base+4];
    op.data = trace_mem[base+5];
    return op;
  endfunction

  function automatic logic needs_memory(slot_op_type op);
    return (op.kind == KIND_LOAD) || (op.kind == KIND_STORE);
  endfunction

  task automatic compare_write(input reg_write_type wb, input int base, input string name);
    check(32'(wb.wren), trace_mem[base], {name, " write enable"});
    if (trace_mem[base][0]) begin // Address and data only matter when enabled.
      check(32'(wb.waddr), trace_mem[base+1], {name, " register"});
      check(wb.wdata, trace_mem[base+2], {name, " data"});
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the trace did not finish within %0d cycles, the DUT seems to hang.",
               cycle_limit);
      $display("Regression failed");
      $fatal(1, "Simulation stopped by the cycle limit.");
    end
  end

  initial begin
    int n_pairs;
    int base;
    int idle;
    int stall;
    int n;
    slot_op_type op0;
    slot_op_type op1;
    in_valid = 1'b0;
    in_slot0 = '0;
    in_slot1 = '0;
    void'($urandom(58));
    $readmemh("test/memory_trace.txt", trace_mem);
    n_pairs = int'(trace_mem[0]);
    if (n_pairs <= 0 || n_pairs > MAX_PAIRS) begin
      $display("The trace file holds no usable pair count.");
      $display("Regression failed");
      $fatal(1, "Trace could not be used.");
    end else begin
      cycle_limit = n_pairs * CYCLES_PER_PAIR;
      wait (reset === 1'b1);
      for (n = 0; n < n_pairs; n++) begin
        base = 1 + n * FIELDS;
        op0 = build_op(base);
        op1 = build_op(base + 6);
        idle = $urandom % 4; // 0 to 3 idle cycles.
        repeat (idle + 1) @(posedge clock);
        #1;
        in_valid = 1'b1;
        in_slot0 = op0;
        in_slot1 = op1;
        do @(negedge clock); while (!in_ready);
        @(posedge clock); // Pair accepted here.
        #1;
        in_valid = 1'b0;
        in_slot0 = '0;
        in_slot1 = '0;
        stall = 0;
        @(negedge clock);
        while (!in_ready) begin
          check(32'(wb0.wren | wb1.wren), 32'd0, $sformatf("pair %0d write during stall", n));
          stall++;
          @(negedge clock);
        end
        // in_ready is back, so this is the write-back cycle.
        compare_write(wb0, base + 12, $sformatf("pair %0d wb0", n));
        compare_write(wb1, base + 15, $sformatf("pair %0d wb1", n));
        check(32'(stall > 0), 32'(needs_memory(op0) || needs_memory(op1)),
              $sformatf("pair %0d stall", n));
      end
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: test/memory_trace.txt
// Columns: slot0 (kind size unsigned rd addr data), slot1 (same), wb0 (en rd data), wb1 (same).
// Kind 0 none, 1 ALU, 2 load, 3 store. Size 0 byte, 1 half, 2 word. All values are hex.
16 // Number of pairs.
1 2 0 01 000 11111111  1 2 0 02 000 22222222  1 01 11111111  1 02 22222222
1 2 0 00 000 deadbeef  1 2 0 00 000 0badf00d  0 00 00000000  0 00 00000000
1 2 0 03 000 cafef00d  0 0 0 00 000 00000000  1 03 cafef00d  0 00 00000000
3 2 0 00 010 12345678  0 0 0 00 000 00000000  0 00 00000000  0 00 00000000
2 2 0 04 010 00000000  1 2 0 05 000 00000055  1 04 12345678  1 05 00000055
3 2 0 00 020 aabbccdd  3 0 0 00 021 00000011  0 00 00000000  0 00 00000000
2 2 0 06 020 00000000  3 0 0 00 023 000000ee  1 06 aabb11dd  0 00 00000000
3 0 0 00 020 00000077  3 0 0 00 022 00000099  0 00 00000000  0 00 00000000
2 2 0 07 020 00000000  0 0 0 00 000 00000000  1 07 ee991177  0 00 00000000
3 2 0 00 030 01020304  3 1 0 00 032 0000abcd  0 00 00000000  0 00 00000000
3 1 0 00 030 ffff8765  2 2 0 08 030 00000000  0 00 00000000  1 08 abcd8765
2 0 0 09 023 00000000  2 0 1 0a 023 00000000  1 09 ffffffee  1 0a 000000ee
2 0 0 0b 020 00000000  2 0 0 0c 022 00000000  1 0b 00000077  1 0c ffffff99
2 1 0 0d 030 00000000  2 1 1 0e 030 00000000  1 0d ffff8765  1 0e 00008765
2 1 0 0f 032 00000000  2 1 1 10 022 00000000  1 0f ffffabcd  1 10 0000ee99
2 0 1 11 021 00000000  2 1 0 12 012 00000000  1 11 00000011  1 12 00001234
3 2 0 00 040 5a5aa5a5  2 2 0 13 040 00000000  0 00 00000000  1 13 5a5aa5a5
2 2 0 00 040 00000000  1 2 0 14 000 00000020  0 00 00000000  1 14 00000020
3 0 0 00 041 0000003c  2 0 1 15 041 00000000  0 00 00000000  1 15 0000003c
2 2 0 16 040 00000000  1 2 0 1f 000 80000000  1 16 5a5a3ca5  1 1f 80000000
3 1 0 00 042 0000beef  2 1 0 17 042 00000000  0 00 00000000  1 17 ffffbeef
1 2 0 18 000 12121212  2 2 0 19 040 00000000  1 18 12121212  1 19 beef3ca5

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(HALF_PERIOD_NS) clock = ~clock;
  end

  initial begin
    reset = 1'b0; // Active low.
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule
